// ==== Makefile ====
# Verilator build and run for the bgpu front end testbench

VERILATOR ?= verilator
TOP       ?= bgpu_frontend_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/bgpu.svh ====
// Subtype sets shared by decode logic
// Include once near the top of a module that matches on them
`ifndef BGPU_SVH
`define BGPU_SVH

// LSU subtypes that carry store data in operand 0
`define INST_STORE {LSU_STORE}

`endif

// ==== hdl/bgpu_frontend.sv ====
// Top of the bgpu instruction front end: program memory, warp fetcher and decoder
// Load the program through prog_*, pulse start_i, then drain the dispatch port
`default_nettype none

module bgpu_frontend (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  start_i,
    input  logic                  prog_we_i,
    input  bgpu_pkg::pc_t         prog_addr_i,
    input  bgpu_pkg::enc_inst_t   prog_data_i,
    input  logic                  br_valid_i,
    input  bgpu_pkg::wid_t        br_warp_i,
    input  bgpu_pkg::pc_t         br_target_i,
    output logic                  disp_valid_o,
    input  logic                  disp_ready_i,
    output bgpu_pkg::pc_t         disp_pc_o,
    output bgpu_pkg::wid_t        disp_warp_o,
    output logic [7:0]            disp_op_o,
    output bgpu_pkg::reg_idx_t    disp_dst_o,
    output bgpu_pkg::reg_idx_t    disp_src0_o,
    output bgpu_pkg::reg_idx_t    disp_src1_o,
    output bgpu_pkg::op_is_reg_t  disp_src_is_reg_o,
    output logic                  done_o
);
    import bgpu_pkg::*;

    logic      mem_rd_en;
    pc_t       mem_rd_addr;
    enc_inst_t mem_rd_data;
    dispatch_t disp;

    fetch_if     fetch_bus ();
    decode_fb_if fb_bus ();

    inst_mem inst_mem_i (
        .clk_i     (clk_i),
        .wr_en_i   (prog_we_i),
        .wr_addr_i (prog_addr_i),
        .wr_data_i (prog_data_i),
        .rd_en_i   (mem_rd_en),
        .rd_addr_i (mem_rd_addr),
        .rd_data_o (mem_rd_data)
    );

    warp_fetcher warp_fetcher_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .start_i       (start_i),
        .br_valid_i    (br_valid_i),
        .br_warp_i     (br_warp_i),
        .br_target_i   (br_target_i),
        .mem_rd_en_o   (mem_rd_en),
        .mem_rd_addr_o (mem_rd_addr),
        .mem_rd_data_i (mem_rd_data),
        .fetch         (fetch_bus.fetcher),
        .fb            (fb_bus.fetcher),
        .done_o        (done_o)
    );

    decoder decoder_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fetch        (fetch_bus.decoder),
        .fb           (fb_bus.decoder),
        .disp_valid_o (disp_valid_o),
        .disp_ready_i (disp_ready_i),
        .disp_o       (disp)
    );

    // Dispatch record out to plain ports
    assign disp_pc_o         = disp.pc;
    assign disp_warp_o       = disp.warp_id;
    assign disp_op_o         = disp.inst;
    assign disp_dst_o        = disp.dst;
    assign disp_src0_o       = disp.src0;
    assign disp_src1_o       = disp.src1;
    assign disp_src_is_reg_o = disp.src_is_reg;
endmodule : bgpu_frontend

`default_nettype wire

// ==== hdl/bgpu_pkg.sv ====
// Shared sizes, instruction encoding and the dispatch record of the bgpu front end
// Modules pull these in with a wildcard import in their body
`default_nettype none

package bgpu_pkg;
    // Core sizes
    localparam int unsigned NumWarps        = 4;
    localparam int unsigned WidWidth        = NumWarps > 1 ? $clog2(NumWarps) : 1;
    localparam int unsigned PcWidth         = 8;
    localparam int unsigned MemDepth        = 2 ** PcWidth;
    localparam int unsigned RegIdxWidth     = 8;
    localparam int unsigned EncInstWidth    = 32;
    localparam int unsigned OperandsPerInst = 2;

    typedef logic [PcWidth-1:0]         pc_t;
    typedef logic [WidWidth-1:0]        wid_t;
    typedef logic [RegIdxWidth-1:0]     reg_idx_t;
    typedef logic [EncInstWidth-1:0]    enc_inst_t;
    typedef logic [OperandsPerInst-1:0] op_is_reg_t;
    typedef logic [4:0]                 subtype_t;

    // Execution unit in the top three bits of the operation byte
    typedef enum logic [2:0] {
        EU_IU  = 3'd0,
        EU_FPU = 3'd1,
        EU_LSU = 3'd2,
        EU_BRU = 3'd3
    } eu_e;

    typedef struct packed {
        eu_e      eu;
        subtype_t subtype;
    } inst_t;

    // Integer unit
    localparam subtype_t IU_ADD  = 5'd0;
    localparam subtype_t IU_SUB  = 5'd1;
    localparam subtype_t IU_MUL  = 5'd2;
    localparam subtype_t IU_ADDI = 5'd3;
    localparam subtype_t IU_SUBI = 5'd4;
    localparam subtype_t IU_MULI = 5'd5;

    // Floating point unit
    localparam subtype_t FPU_ADD  = 5'd0;
    localparam subtype_t FPU_EXP2 = 5'd1;

    // Load store unit
    localparam subtype_t LSU_LOAD  = 5'd0;
    localparam subtype_t LSU_STORE = 5'd1;

    // Branch unit
    localparam subtype_t BRU_JMP  = 5'd0;
    localparam subtype_t BRU_SYNC = 5'd1;
    localparam subtype_t BRU_BEQZ = 5'd2;

    // All-ones operation byte ends the warp
    localparam logic [7:0] StopOp = 8'hFF;

    typedef struct packed {
        pc_t        pc;
        wid_t       warp_id;
        inst_t      inst;
        reg_idx_t   dst;
        reg_idx_t   src1;
        reg_idx_t   src0;
        op_is_reg_t src_is_reg;
    } dispatch_t;
endpackage : bgpu_pkg

`default_nettype wire

// ==== hdl/decode_fb_if.sv ====
// Decode result returned from the decoder to the warp fetcher
// Fields other than decoded only count in a cycle where decoded is high
`default_nettype none

interface decode_fb_if;
    import bgpu_pkg::*;

    logic decoded;
    wid_t warp_id;
    pc_t  next_pc;
    logic stop;
    logic branch;
    logic sync;

    modport decoder (
        output decoded, warp_id, next_pc, stop, branch, sync
    );

    modport fetcher (
        input decoded, warp_id, next_pc, stop, branch, sync
    );
endinterface : decode_fb_if

`default_nettype wire

// ==== hdl/decoder.sv ====
// Instruction decoder with a registered dispatch stage
// Feedback to the fetcher is combinational; ordinary instructions go to dispatch a cycle later
`default_nettype none

`include "bgpu.svh"

module decoder (
    input  logic                clk_i,
    input  logic                rst_n_i,
    fetch_if.decoder            fetch,
    decode_fb_if.decoder        fb,
    output logic                disp_valid_o,
    input  logic                disp_ready_i,
    output bgpu_pkg::dispatch_t disp_o
);
    import bgpu_pkg::*;

    inst_t       inst;
    reg_idx_t    dst;
    reg_idx_t    src0;
    reg_idx_t    src1;
    op_is_reg_t  src_is_reg;
    logic [15:0] jmp_offset;
    logic        is_jump;
    logic        transfer;
    logic        to_dispatch;
    logic        disp_valid_q;
    dispatch_t   disp_q;

    // Field split of the encoded word
    assign inst       = inst_t'(fetch.inst[31:24]);
    assign dst        = fetch.inst[23:16];
    assign src1       = fetch.inst[15:8];
    assign src0       = fetch.inst[7:0];
    assign jmp_offset = fetch.inst[15:0];

    assign fetch.ready = !disp_valid_q || disp_ready_i;
    assign transfer    = fetch.valid && fetch.ready;

    assign fb.decoded = transfer;
    assign fb.warp_id = fetch.warp_id;

    always_comb begin : decode_inst
        src_is_reg = '0;
        is_jump    = 1'b0;
        fb.stop    = 1'b0;
        fb.branch  = 1'b0;
        fb.sync    = 1'b0;
        fb.next_pc = fetch.pc + pc_t'(1);

        if (fetch.inst[31:24] == StopOp) begin
            fb.stop = 1'b1;
        end

        if (inst.eu == EU_IU) begin
            if (inst.subtype inside {IU_ADD, IU_SUB, IU_MUL}) begin
                src_is_reg = 2'b11;
            end
            // Immediate in operand 0
            if (inst.subtype inside {IU_ADDI, IU_SUBI, IU_MULI}) begin
                src_is_reg = 2'b10;
            end
        end else if (inst.eu == EU_FPU) begin
            src_is_reg = 2'b11;
            if (inst.subtype == FPU_EXP2) begin
                src_is_reg[0] = 1'b0;
            end
        end else if (inst.eu == EU_LSU) begin
            // Operand 1 is the address, operand 0 the store data
            src_is_reg[0] = inst.subtype inside `INST_STORE;
            src_is_reg[1] = 1'b1;
        end else if (inst.eu == EU_BRU) begin
            if (inst.subtype == BRU_JMP) begin
                is_jump = 1'b1;
                // Offset reduced modulo the PC width equals its sign extension
                fb.next_pc = fetch.pc + pc_t'(jmp_offset) + pc_t'(1);
            end else if (inst.subtype == BRU_SYNC) begin
                fb.sync = 1'b1;
            end else begin
                // Condition register in operand 1
                src_is_reg = 2'b10;
                fb.branch  = 1'b1;
            end
        end
    end : decode_inst

    // Control instructions end here
    assign to_dispatch = transfer && !(fb.stop || fb.sync || is_jump);

    always_ff @(posedge clk_i or negedge rst_n_i) begin : disp_valid_reg
        if (!rst_n_i) begin
            disp_valid_q <= 1'b0;
        end else if (to_dispatch) begin
            disp_valid_q <= 1'b1;
        end else if (disp_ready_i) begin
            disp_valid_q <= 1'b0;
        end
    end : disp_valid_reg

    always_ff @(posedge clk_i) begin : disp_payload_reg
        if (to_dispatch) begin
            disp_q.pc         <= fetch.pc;
            disp_q.warp_id    <= fetch.warp_id;
            disp_q.inst       <= inst;
            disp_q.dst        <= dst;
            disp_q.src1       <= src1;
            disp_q.src0       <= src0;
            disp_q.src_is_reg <= src_is_reg;
        end
    end : disp_payload_reg

    assign disp_valid_o = disp_valid_q;
    assign disp_o       = disp_q;
endmodule : decoder

`default_nettype wire

// ==== hdl/fetch_if.sv ====
// One fetched instruction from the warp fetcher to the decoder
// A transfer happens when valid and ready are both high, fields hold while stalled
`default_nettype none

interface fetch_if;
    import bgpu_pkg::*;

    logic      valid;
    logic      ready;
    pc_t       pc;
    wid_t      warp_id;
    enc_inst_t inst;

    modport fetcher (
        output valid, pc, warp_id, inst,
        input  ready
    );

    modport decoder (
        input  valid, pc, warp_id, inst,
        output ready
    );
endinterface : fetch_if

`default_nettype wire

// ==== hdl/inst_mem.sv ====
// Program memory shared by all warps
// Loaded through the write port before launch, read data arrives one cycle after rd_en_i
`default_nettype none

module inst_mem (
    input  logic                clk_i,
    input  logic                wr_en_i,
    input  bgpu_pkg::pc_t       wr_addr_i,
    input  bgpu_pkg::enc_inst_t wr_data_i,
    input  logic                rd_en_i,
    input  bgpu_pkg::pc_t       rd_addr_i,
    output bgpu_pkg::enc_inst_t rd_data_o
);
    import bgpu_pkg::*;

    enc_inst_t mem_q [MemDepth];

    always_ff @(posedge clk_i) begin : mem_access
        if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_data_i;
        end
        // Read register keeps its word while no read is issued
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_addr_i];
        end
    end : mem_access
endmodule : inst_mem

`default_nettype wire

// ==== hdl/warp_fetcher.sv ====
// Per-warp PC table with round-robin fetch and barrier handling
// Issues one memory read per cycle and presents the word on the fetch interface
`default_nettype none

module warp_fetcher (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                start_i,
    input  logic                br_valid_i,
    input  bgpu_pkg::wid_t      br_warp_i,
    input  bgpu_pkg::pc_t       br_target_i,
    output logic                mem_rd_en_o,
    output bgpu_pkg::pc_t       mem_rd_addr_o,
    input  bgpu_pkg::enc_inst_t mem_rd_data_i,
    fetch_if.fetcher            fetch,
    decode_fb_if.fetcher        fb,
    output logic                done_o
);
    import bgpu_pkg::*;

    logic [NumWarps-1:0] ready_q, ready_d;
    logic [NumWarps-1:0] inflight_q, inflight_d;
    logic [NumWarps-1:0] parked_q, parked_d;
    logic [NumWarps-1:0] barrier_q, barrier_d;
    logic [NumWarps-1:0] stopped_q, stopped_d;
    logic [NumWarps-1:0] eligible;
    pc_t                 pc_q [NumWarps];

    wid_t last_q;
    wid_t grant_wid;
    logic grant_valid;
    logic issue;
    logic barrier_release;
    logic stage_valid_q;
    pc_t  stage_pc_q;
    wid_t stage_wid_q;

    assign eligible = ready_q & ~inflight_q;

    // Round robin, starting after the last granted warp
    always_comb begin : rr_pick
        wid_t cand;
        grant_valid = 1'b0;
        grant_wid   = last_q;
        for (int i = 1; i <= NumWarps; i++) begin
            cand = last_q + wid_t'(i);
            if (!grant_valid && eligible[cand]) begin
                grant_valid = 1'b1;
                grant_wid   = cand;
            end
        end
    end : rr_pick

    // Only read when the fetch stage is free or draining this cycle
    assign issue         = grant_valid && (!stage_valid_q || fetch.ready);
    assign mem_rd_en_o   = issue;
    assign mem_rd_addr_o = pc_q[grant_wid];

    // Every live warp waits at the barrier
    assign barrier_release = (|barrier_q) && ((barrier_q | stopped_q) == '1);

    always_comb begin : table_next
        ready_d    = ready_q;
        inflight_d = inflight_q;
        parked_d   = parked_q;
        barrier_d  = barrier_q;
        stopped_d  = stopped_q;
        if (issue) begin
            inflight_d[grant_wid] = 1'b1;
        end
        if (fb.decoded) begin
            inflight_d[fb.warp_id] = 1'b0;
            if (fb.stop) begin
                ready_d[fb.warp_id]   = 1'b0;
                stopped_d[fb.warp_id] = 1'b1;
            end else if (fb.branch) begin
                ready_d[fb.warp_id]  = 1'b0;
                parked_d[fb.warp_id] = 1'b1;
            end else if (fb.sync) begin
                ready_d[fb.warp_id]   = 1'b0;
                barrier_d[fb.warp_id] = 1'b1;
            end
        end
        if (br_valid_i && parked_q[br_warp_i]) begin
            parked_d[br_warp_i] = 1'b0;
            ready_d[br_warp_i]  = 1'b1;
        end
        if (barrier_release) begin
            ready_d   = ready_d | barrier_q;
            barrier_d = '0;
        end
        // Launch all warps together
        if (start_i) begin
            ready_d    = '1;
            inflight_d = '0;
            parked_d   = '0;
            barrier_d  = '0;
            stopped_d  = '0;
        end
    end : table_next

    always_ff @(posedge clk_i or negedge rst_n_i) begin : ctrl_regs
        if (!rst_n_i) begin
            ready_q       <= '0;
            inflight_q    <= '0;
            parked_q      <= '0;
            barrier_q     <= '0;
            stopped_q     <= '0;
            last_q        <= '0;
            stage_valid_q <= 1'b0;
        end else begin
            ready_q    <= ready_d;
            inflight_q <= inflight_d;
            parked_q   <= parked_d;
            barrier_q  <= barrier_d;
            stopped_q  <= stopped_d;
            if (issue) begin
                last_q        <= grant_wid;
                stage_valid_q <= 1'b1;
            end else if (fetch.ready) begin
                stage_valid_q <= 1'b0;
            end
        end
    end : ctrl_regs

    always_ff @(posedge clk_i) begin : pc_regs
        for (int w = 0; w < NumWarps; w++) begin
            if (start_i) begin
                pc_q[w] <= '0;
            end else if (fb.decoded && fb.warp_id == wid_t'(w)) begin
                pc_q[w] <= fb.next_pc;
            end else if (br_valid_i && parked_q[w] && br_warp_i == wid_t'(w)) begin
                pc_q[w] <= br_target_i;
            end
        end
        if (issue) begin
            stage_pc_q  <= pc_q[grant_wid];
            stage_wid_q <= grant_wid;
        end
    end : pc_regs

    assign fetch.valid   = stage_valid_q;
    assign fetch.pc      = stage_pc_q;
    assign fetch.warp_id = stage_wid_q;
    assign fetch.inst    = mem_rd_data_i;

    assign done_o = &stopped_q;
endmodule : warp_fetcher

`default_nettype wire

// ==== verification/bgpu_frontend_tb.sv ====
// Directed testbench for the bgpu front end
// Loads a program, launches all warps and checks every dispatch against a software walk
`default_nettype none

module bgpu_frontend_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import bgpu_pkg::*;

    logic       clk_i;
    logic       rst_n_i;
    logic       start_i;
    logic       prog_we_i;
    pc_t        prog_addr_i;
    enc_inst_t  prog_data_i;
    logic       br_valid_i;
    wid_t       br_warp_i;
    pc_t        br_target_i;
    logic       disp_valid_o;
    logic       disp_ready_i;
    pc_t        disp_pc_o;
    wid_t       disp_warp_o;
    logic [7:0] disp_op_o;
    reg_idx_t   disp_dst_o;
    reg_idx_t   disp_src0_o;
    reg_idx_t   disp_src1_o;
    op_is_reg_t disp_src_is_reg_o;
    logic       done_o;

    // Program image and expected per-warp dispatch stream
    enc_inst_t   prog [MemDepth];
    pc_t         exp_pc[$];
    enc_inst_t   exp_word[$];
    int          sync_mark;
    int          ptr [NumWarps];
    bit          parked [NumWarps];
    int          park_wait [NumWarps];
    bit          hold_q;
    logic [44:0] held_fields;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     dispatched = 0;
    int     cycle_count = 0;
    // 52 program words over all tests with a generous margin per warp and word
    int     cycle_limit = 52 * NumWarps * 25;

    bgpu_frontend bgpu_frontend_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic report_and_finish(input bit timed_out);
        $display("Summary: %0d checks, %0d dispatches, %0d errors", checks, dispatched, errors);
        if (errors == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    always @(posedge clk_i) begin : watchdog
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            report_and_finish(1'b1);
        end
    end : watchdog

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    function automatic enc_inst_t make_word(input eu_e eu, input subtype_t sub,
                                            input reg_idx_t dst, input reg_idx_t s1,
                                            input reg_idx_t s0);
        return {eu, sub, dst, s1, s0};
    endfunction

    function automatic enc_inst_t jump_word(input logic [15:0] offset);
        return {EU_BRU, BRU_JMP, 8'h00, offset};
    endfunction

    function automatic bit is_op(input enc_inst_t word, input eu_e eu, input subtype_t sub);
        return word[31:29] == eu && word[28:24] == sub;
    endfunction

    // Operand flags with bit 0 for operand 0
    function automatic op_is_reg_t reg_flags(input enc_inst_t word);
        op_is_reg_t flags;
        flags = 2'b00;
        if (word[31:29] == EU_IU) begin
            if (word[28:24] inside {IU_ADD, IU_SUB, IU_MUL}) begin
                flags = 2'b11;
            end else if (word[28:24] inside {IU_ADDI, IU_SUBI, IU_MULI}) begin
                flags = 2'b10;
            end
        end else if (word[31:29] == EU_FPU) begin
            flags = (word[28:24] == FPU_EXP2) ? 2'b10 : 2'b11;
        end else if (word[31:29] == EU_LSU) begin
            flags = (word[28:24] == LSU_STORE) ? 2'b11 : 2'b10;
        end else if (is_op(word, EU_BRU, BRU_BEQZ)) begin
            flags = 2'b10;
        end
        return flags;
    endfunction

    // Walk the program as one warp sees it with branches resuming at target
    function automatic void build_expected(input pc_t target);
        pc_t       pc;
        enc_inst_t word;
        int        next;
        bit        finished;
        exp_pc.delete();
        exp_word.delete();
        sync_mark = -1;
        pc = '0;
        finished = 1'b0;
        for (int step = 0; step < int'(MemDepth) && !finished; step++) begin
            word = prog[pc];
            if (word[31:24] == StopOp) begin
                finished = 1'b1;
            end else if (is_op(word, EU_BRU, BRU_JMP)) begin
                next = int'(pc) + int'($signed(word[15:0])) + 1;
                // PC wraps at the memory size
                pc = pc_t'(next);
            end else if (is_op(word, EU_BRU, BRU_SYNC)) begin
                sync_mark = exp_pc.size();
                pc = pc + pc_t'(1);
            end else begin
                exp_pc.push_back(pc);
                exp_word.push_back(word);
                pc = is_op(word, EU_BRU, BRU_BEQZ) ? target : pc + pc_t'(1);
            end
        end
    endfunction

    task automatic load_program(input int len);
        for (int a = 0; a < len; a++) begin
            @(negedge clk_i);
            prog_we_i   = 1'b1;
            prog_addr_i = pc_t'(a);
            prog_data_i = prog[a];
        end
        @(negedge clk_i);
        prog_we_i = 1'b0;
    endtask

    task automatic drive_cycle(input bit random_ready, input pc_t target);
        int rnd;
        br_valid_i = 1'b0;
        if (random_ready && !done_o) begin
            rnd = $random(seed);
            disp_ready_i = rnd[0];
        end else begin
            disp_ready_i = 1'b1;
        end
        for (int w = 0; w < NumWarps; w++) begin
            if (parked[w]) begin
                park_wait[w]++;
            end
            // Parked warps resolve one per cycle after a delay that grows with the warp id
            if (!br_valid_i && parked[w] && park_wait[w] > 3 + 6 * w) begin
                br_valid_i  = 1'b1;
                br_warp_i   = wid_t'(w);
                br_target_i = target;
                parked[w]   = 1'b0;
            end
        end
    endtask

    // Runs after driving because valid and ready then describe the next rising edge
    task automatic sample_dispatch();
        logic [44:0] fields;
        int          w;
        int          idx;
        enc_inst_t   word;
        fields = {disp_valid_o, disp_pc_o, disp_warp_o, disp_op_o, disp_dst_o,
                  disp_src0_o, disp_src1_o, disp_src_is_reg_o};
        if (hold_q && fields !== held_fields) begin
            report_failure("dispatch output changed while stalled");
        end
        hold_q      = disp_valid_o && !disp_ready_i;
        held_fields = fields;
        if (disp_valid_o && disp_ready_i) begin
            w = int'(disp_warp_o);
            idx = ptr[w];
            dispatched++;
            if (parked[w]) begin
                report_failure($sformatf("warp %0d dispatched while parked on a branch", w));
            end
            if (idx >= exp_pc.size()) begin
                report_failure($sformatf("warp %0d dispatched past its last instruction", w));
            end else begin
                word = exp_word[idx];
                check_value($sformatf("disp_pc_o warp %0d", w), 32'(disp_pc_o),
                            32'(exp_pc[idx]));
                check_value("disp_op_o", 32'(disp_op_o), 32'(word[31:24]));
                check_value("disp_dst_o", 32'(disp_dst_o), 32'(word[23:16]));
                check_value("disp_src1_o", 32'(disp_src1_o), 32'(word[15:8]));
                check_value("disp_src0_o", 32'(disp_src0_o), 32'(word[7:0]));
                check_value("disp_src_is_reg_o", 32'(disp_src_is_reg_o),
                            32'(reg_flags(word)));
                // Work after the sync waits until every warp has finished the work before it
                for (int v = 0; v < NumWarps; v++) begin
                    if (sync_mark >= 0 && idx >= sync_mark && ptr[v] < sync_mark) begin
                        report_failure($sformatf("warp %0d passed the barrier before warp %0d",
                                                 w, v));
                    end
                end
                if (is_op(word, EU_BRU, BRU_BEQZ)) begin
                    parked[w]    = 1'b1;
                    park_wait[w] = 0;
                end
                ptr[w] = idx + 1;
            end
        end
    endtask

    task automatic run_program(input pc_t target, input bit random_ready);
        int drain;
        build_expected(target);
        for (int w = 0; w < NumWarps; w++) begin
            ptr[w]       = 0;
            parked[w]    = 1'b0;
            park_wait[w] = 0;
        end
        hold_q = 1'b0;
        @(negedge clk_i);
        start_i = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        // Launch makes every warp live again
        check_value("done_o", 32'(done_o), 32'd0);
        drain = 0;
        while (drain < 4) begin
            @(negedge clk_i);
            drive_cycle(random_ready, target);
            sample_dispatch();
            if (done_o) begin
                drain++;
            end
        end
        check_value("disp_valid_o", 32'(disp_valid_o), 32'd0);
        for (int w = 0; w < NumWarps; w++) begin
            check_value($sformatf("dispatch count warp %0d", w), 32'(ptr[w]),
                        32'(exp_pc.size()));
        end
    endtask

    task automatic test_operand_typing();
        prog[0]  = make_word(EU_IU, IU_ADD, 8'h10, 8'h21, 8'h32);
        prog[1]  = make_word(EU_IU, IU_SUB, 8'h11, 8'h22, 8'h33);
        prog[2]  = make_word(EU_IU, IU_MUL, 8'h12, 8'h23, 8'h34);
        prog[3]  = make_word(EU_IU, IU_ADDI, 8'h13, 8'h24, 8'h7f);
        prog[4]  = make_word(EU_IU, IU_SUBI, 8'h14, 8'h25, 8'h80);
        prog[5]  = make_word(EU_IU, IU_MULI, 8'h15, 8'h26, 8'h05);
        prog[6]  = make_word(EU_FPU, FPU_ADD, 8'h16, 8'h27, 8'h38);
        prog[7]  = make_word(EU_FPU, FPU_EXP2, 8'h17, 8'h28, 8'h00);
        prog[8]  = make_word(EU_LSU, LSU_LOAD, 8'h18, 8'h29, 8'h04);
        prog[9]  = make_word(EU_LSU, LSU_STORE, 8'h00, 8'h2a, 8'h3b);
        prog[10] = {StopOp, 24'h0};
        load_program(11);
        run_program('0, 1'b0);
    endtask

    task automatic test_interleave_stop();
        for (int i = 0; i < 8; i++) begin
            prog[i] = make_word(EU_IU, IU_ADD, 8'(i), 8'(i + 1), 8'(i + 2));
        end
        prog[8]  = {StopOp, 24'h0};
        // Never reached
        prog[9]  = make_word(EU_IU, IU_SUB, 8'hee, 8'hee, 8'hee);
        prog[10] = make_word(EU_IU, IU_SUB, 8'hef, 8'hef, 8'hef);
        load_program(11);
        run_program('0, 1'b0);
    endtask

    task automatic test_jump();
        prog[0] = make_word(EU_IU, IU_ADD, 8'h01, 8'h02, 8'h03);
        prog[1] = jump_word(16'h0003);
        prog[2] = make_word(EU_IU, IU_MUL, 8'hd0, 8'hd1, 8'hd2);
        prog[3] = make_word(EU_IU, IU_ADD, 8'h04, 8'h05, 8'h06);
        prog[4] = {StopOp, 24'h0};
        prog[5] = make_word(EU_IU, IU_SUB, 8'h07, 8'h08, 8'h09);
        prog[6] = jump_word(16'hfffc);
        prog[7] = make_word(EU_IU, IU_MUL, 8'hd3, 8'hd4, 8'hd5);
        load_program(8);
        run_program('0, 1'b0);
    endtask

    task automatic test_branch_park();
        prog[0] = make_word(EU_IU, IU_ADD, 8'h01, 8'h02, 8'h03);
        prog[1] = make_word(EU_BRU, BRU_BEQZ, 8'h00, 8'h05, 8'h00);
        prog[2] = make_word(EU_IU, IU_MUL, 8'hd0, 8'hd1, 8'hd2);
        prog[3] = make_word(EU_IU, IU_SUB, 8'hd3, 8'hd4, 8'hd5);
        prog[4] = make_word(EU_IU, IU_ADD, 8'h06, 8'h07, 8'h08);
        prog[5] = {StopOp, 24'h0};
        load_program(6);
        run_program(pc_t'(4), 1'b0);
    endtask

    task automatic test_sync_barrier();
        // Staggered branch resolution makes the warps reach the sync at different times
        prog[0] = make_word(EU_IU, IU_ADD, 8'h01, 8'h02, 8'h03);
        prog[1] = make_word(EU_BRU, BRU_BEQZ, 8'h00, 8'h0a, 8'h00);
        prog[2] = make_word(EU_IU, IU_MUL, 8'h04, 8'h05, 8'h06);
        prog[3] = make_word(EU_BRU, BRU_SYNC, 8'h00, 8'h00, 8'h00);
        prog[4] = make_word(EU_IU, IU_SUB, 8'h07, 8'h08, 8'h09);
        prog[5] = {StopOp, 24'h0};
        load_program(6);
        run_program(pc_t'(2), 1'b0);
    endtask

    task automatic test_back_pressure();
        prog[0] = make_word(EU_IU, IU_ADD, 8'h01, 8'h02, 8'h03);
        prog[1] = make_word(EU_IU, IU_ADDI, 8'h04, 8'h05, 8'h2c);
        prog[2] = make_word(EU_FPU, FPU_EXP2, 8'h06, 8'h07, 8'h00);
        prog[3] = jump_word(16'h0001);
        prog[4] = make_word(EU_IU, IU_MUL, 8'hd0, 8'hd1, 8'hd2);
        prog[5] = make_word(EU_LSU, LSU_LOAD, 8'h08, 8'h09, 8'h10);
        prog[6] = make_word(EU_LSU, LSU_STORE, 8'h00, 8'h0a, 8'h0b);
        prog[7] = make_word(EU_BRU, BRU_SYNC, 8'h00, 8'h00, 8'h00);
        prog[8] = make_word(EU_IU, IU_SUB, 8'h0c, 8'h0d, 8'h0e);
        prog[9] = {StopOp, 24'h0};
        load_program(10);
        run_program('0, 1'b1);
    endtask

    initial begin
        seed         = 32'h5c85_5b89;
        rst_n_i      = 1'b0;
        start_i      = 1'b0;
        prog_we_i    = 1'b0;
        prog_addr_i  = '0;
        prog_data_i  = '0;
        br_valid_i   = 1'b0;
        br_warp_i    = '0;
        br_target_i  = '0;
        disp_ready_i = 1'b1;
        hold_q       = 1'b0;
        held_fields  = '0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        test_operand_typing();
        test_interleave_stop();
        test_jump();
        test_branch_park();
        test_sync_barrier();
        test_back_pressure();
        report_and_finish(1'b0);
    end
endmodule : bgpu_frontend_tb

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/bgpu_pkg.sv
hdl/fetch_if.sv
hdl/decode_fb_if.sv
hdl/inst_mem.sv
hdl/warp_fetcher.sv
hdl/decoder.sv
hdl/bgpu_frontend.sv
verification/bgpu_frontend_tb.sv
